/* common/microstepper_macros.svh */
`ifndef MICROSTEPPER_MACROS_SVH
`define MICROSTEPPER_MACROS_SVH

// Counts in one electrical cycle
`define MS_CYCLE 192

// Coil B starts a quarter cycle ahead of coil A
`define MS_B_OFFSET 48

// Register reset values
`define MS_FASTDECAY_DEFAULT 706
`define MS_OFF_TIME_DEFAULT 800
`define MS_BLANK_TIME_DEFAULT 20
`define MS_MIN_ON_DEFAULT 0

// AXI4-Lite bus widths
`define AXIL_ADDR_W 4
`define AXIL_DATA_W 32

`endif

/* common/microstepper_pkg.sv */
`default_nettype none

package microstepper_pkg;

  // Electrical phase of one coil from 0 to 191
  typedef logic [7:0] phase_t;

  // Off time, fast-decay threshold, and the widened blank and minimum-on counts
  typedef logic [9:0] timer_t;

  // Current reference for the external DAC
  typedef logic [7:0] level_t;

  // Byte address inside the register block
  typedef logic [3:0] reg_addr_t;

  localparam reg_addr_t ADDR_CTRL   = 4'h0;
  localparam reg_addr_t ADDR_OFF    = 4'h4;
  localparam reg_addr_t ADDR_TIMES  = 4'h8;
  // Read only
  localparam reg_addr_t ADDR_STATUS = 4'hC;

endpackage

`default_nettype wire

/* hw/microstep_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "microstepper_macros.svh"

module microstep_sequencer (
  input  logic                      clk,
  input  logic                      resetn,
  input  microstepper_pkg::phase_t  phase_a,
  input  microstepper_pkg::phase_t  phase_b,
  output logic                      s1,
  output logic                      s2,
  output logic                      s3,
  output logic                      s4,
  output microstepper_pkg::level_t  dac_a,
  output microstepper_pkg::level_t  dac_b
);

  import microstepper_pkg::*;

  localparam phase_t HALF    = phase_t'(`MS_CYCLE / 2);
  localparam phase_t QUARTER = phase_t'(`MS_CYCLE / 4);

  // Triangle reference that rises over the first quarter of each half cycle
  function automatic level_t tri_level(input phase_t p);
    phase_t m;
    m = (p >= HALF) ? p - HALF : p;
    if (m < QUARTER) begin
      return m * 8'd5;
    end
    return (HALF - 8'd1 - m) * 8'd5;
  endfunction

  always_ff @(posedge clk) begin
    if (!resetn) begin
      s1    <= 1'b0;
      s2    <= 1'b0;
      s3    <= 1'b0;
      s4    <= 1'b0;
      dac_a <= '0;
      dac_b <= '0;
    end else begin
      // The first half cycle drives current one way and the second half the other
      s1    <= (phase_a < HALF);
      s2    <= (phase_a >= HALF);
      s3    <= (phase_b < HALF);
      s4    <= (phase_b >= HALF);
      dac_a <= tri_level(phase_a);
      dac_b <= tri_level(phase_b);
    end
  end

endmodule

`default_nettype wire

/* hw/coil_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module coil_timer (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      start,
  input  microstepper_pkg::timer_t  off_time,
  input  logic [7:0]                blank_time,
  input  logic [7:0]                min_on_time,
  output microstepper_pkg::timer_t  off_count,
  output logic                      blank_busy,
  output logic                      min_on_busy
);

  import microstepper_pkg::*;

  timer_t blank_count;
  timer_t min_on_count;
  logic   off_last;

  // The next two timers load on the last cycle of the off time
  assign off_last = (off_count == timer_t'(1));

  always_ff @(posedge clk) begin
    if (!resetn) begin
      off_count <= '0;
    end else if (start) begin
      off_count <= off_time;
    end else if (off_count != '0) begin
      off_count <= off_count - 1'b1;
    end
  end

  // Blanking hides the switching spike from the comparator
  always_ff @(posedge clk) begin
    if (!resetn) begin
      blank_count <= '0;
    end else if (off_last) begin
      blank_count <= timer_t'(blank_time);
    end else if (blank_count != '0) begin
      blank_count <= blank_count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      min_on_count <= '0;
    end else if (off_last) begin
      min_on_count <= timer_t'(min_on_time);
    end else if (min_on_count != '0) begin
      min_on_count <= min_on_count - 1'b1;
    end
  end

  assign blank_busy  = (blank_count != '0);
  assign min_on_busy = (min_on_count != '0);

endmodule

`default_nettype wire

/* hw/axil_config_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "microstepper_macros.svh"

module axil_config_regs (
  input  logic                        clk,
  input  logic                        resetn,
  input  logic [`AXIL_ADDR_W-1:0]     awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [`AXIL_DATA_W-1:0]     wdata,
  input  logic [`AXIL_DATA_W/8-1:0]   wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output logic                        bvalid,
  output logic [1:0]                  bresp,
  input  logic                        bready,
  input  logic [`AXIL_ADDR_W-1:0]     araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic                        rvalid,
  output logic [`AXIL_DATA_W-1:0]     rdata,
  output logic [1:0]                  rresp,
  input  logic                        rready,
  input  microstepper_pkg::phase_t    phase_a,
  input  microstepper_pkg::phase_t    phase_b,
  input  logic                        faultn,
  output logic                        enable,
  output logic                        invert_highside,
  output logic                        invert_lowside,
  output microstepper_pkg::timer_t    off_time,
  output microstepper_pkg::timer_t    fastdecay_threshold,
  output logic [7:0]                  blank_time,
  output logic [7:0]                  min_on_time
);

  import microstepper_pkg::*;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  reg_addr_t               wr_addr;
  reg_addr_t               rd_addr;
  logic                    wr_fire;
  logic                    rd_fire;
  logic                    wr_err;
  logic                    rd_err;
  logic [`AXIL_DATA_W-1:0] rd_word;

  assign wr_addr = reg_addr_t'(awaddr);
  assign rd_addr = reg_addr_t'(araddr);
  assign wr_fire = awvalid & awready & wvalid & wready;
  assign rd_fire = arvalid & arready;

  // Address and data are taken together with one write in flight
  always_ff @(posedge clk) begin
    if (!resetn) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      awready <= awvalid & wvalid & ~awready & ~bvalid;
      wready  <= awvalid & wvalid & ~awready & ~bvalid;
      arready <= arvalid & ~arready & ~rvalid;
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      enable              <= 1'b0;
      invert_highside     <= 1'b0;
      invert_lowside      <= 1'b0;
      off_time            <= timer_t'(`MS_OFF_TIME_DEFAULT);
      fastdecay_threshold <= timer_t'(`MS_FASTDECAY_DEFAULT);
      blank_time          <= 8'(`MS_BLANK_TIME_DEFAULT);
      min_on_time         <= 8'(`MS_MIN_ON_DEFAULT);
    end else if (wr_fire) begin
      case (wr_addr)
        ADDR_CTRL: begin
          if (wstrb[0]) {invert_lowside, invert_highside, enable} <= wdata[2:0];
        end
        ADDR_OFF: begin
          if (wstrb[0]) off_time[7:0] <= wdata[7:0];
          if (wstrb[1]) off_time[9:8] <= wdata[9:8];
          if (wstrb[2]) fastdecay_threshold[7:0] <= wdata[23:16];
          if (wstrb[3]) fastdecay_threshold[9:8] <= wdata[25:24];
        end
        ADDR_TIMES: begin
          if (wstrb[0]) blank_time <= wdata[7:0];
          if (wstrb[1]) min_on_time <= wdata[15:8];
        end
        default: begin
        end
      endcase
    end
  end

  // A write to the read-only status register is dropped without error
  assign wr_err = ~(wr_addr inside {ADDR_CTRL, ADDR_OFF, ADDR_TIMES, ADDR_STATUS});

  always_comb begin
    rd_word = '0;
    rd_err  = 1'b0;
    case (rd_addr)
      ADDR_CTRL:   rd_word[2:0] = {invert_lowside, invert_highside, enable};
      ADDR_OFF:    rd_word = {6'b0, fastdecay_threshold, 6'b0, off_time};
      ADDR_TIMES:  rd_word[15:0] = {min_on_time, blank_time};
      ADDR_STATUS: rd_word[16:0] = {faultn, phase_b, phase_a};
      default:     rd_err = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
    end
    if (rd_fire) begin
      rdata <= rd_word;
      rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

endmodule

`default_nettype wire

/* hw/microstepper_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "microstepper_macros.svh"

module microstepper_control (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      step,
  input  logic                      dir,
  input  logic                      analog_cmp1,
  input  logic                      analog_cmp2,
  input  logic                      enable,
  input  logic                      invert_highside,
  input  logic                      invert_lowside,
  input  microstepper_pkg::timer_t  fastdecay_threshold,
  input  logic                      s1,
  input  logic                      s2,
  input  logic                      s3,
  input  logic                      s4,
  input  microstepper_pkg::timer_t  off_count_a,
  input  microstepper_pkg::timer_t  off_count_b,
  input  logic                      blank_busy_a,
  input  logic                      blank_busy_b,
  input  logic                      min_on_busy_a,
  input  logic                      min_on_busy_b,
  output microstepper_pkg::phase_t  phase_a,
  output microstepper_pkg::phase_t  phase_b,
  output logic                      offtimer_start_a,
  output logic                      offtimer_start_b,
  output logic                      faultn,
  output logic                      phase_a1_h,
  output logic                      phase_a2_h,
  output logic                      phase_b1_h,
  output logic                      phase_b2_h,
  output logic                      phase_a1_l,
  output logic                      phase_a2_l,
  output logic                      phase_b1_l,
  output logic                      phase_b2_l
);

  import microstepper_pkg::*;

  localparam phase_t PHASE_LAST = phase_t'(`MS_CYCLE - 1);

  logic [2:0] step_sync;
  logic [2:0] dir_sync;
  logic       step_rise;
  logic       fast_a;
  logic       fast_b;
  logic       slow_a;
  logic       slow_b;
  logic [3:0] pol;
  logic [3:0] fast_sel;
  logic [3:0] slow_sel;
  logic [3:0] high_next;
  logic [3:0] low_next;
  logic [3:0] high_q;
  logic [3:0] low_q;

  // One step of the phase counter with wrap at both ends
  function automatic phase_t next_phase(input phase_t p, input logic up);
    if (up) begin
      return (p == PHASE_LAST) ? '0 : p + 1'b1;
    end
    return (p == '0) ? PHASE_LAST : p - 1'b1;
  endfunction

  // Step and direction come from another clock domain
  always_ff @(posedge clk) begin
    step_sync <= {step_sync[1:0], step};
    dir_sync  <= {dir_sync[1:0], dir};
  end

  assign step_rise = step_sync[1] & ~step_sync[2];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      phase_a <= '0;
      phase_b <= phase_t'(`MS_B_OFFSET);
    end else if (step_rise) begin
      phase_a <= next_phase(phase_a, dir_sync[2]);
      phase_b <= next_phase(phase_b, dir_sync[2]);
    end
  end

  // Start the off time on peak current once blanking is over
  assign offtimer_start_a = analog_cmp1 & ~blank_busy_a & (off_count_a == '0);
  assign offtimer_start_b = analog_cmp2 & ~blank_busy_b & (off_count_b == '0);

  // Off time begins fast and finishes slow
  assign fast_a = (off_count_a != '0) & (off_count_a >= fastdecay_threshold);
  assign fast_b = (off_count_b != '0) & (off_count_b >= fastdecay_threshold);
  assign slow_a = (off_count_a != '0) & ~fast_a;
  assign slow_b = (off_count_b != '0) & ~fast_b;

  assign pol      = {s4, s3, s2, s1};
  assign fast_sel = {fast_b, fast_b, fast_a, fast_a};
  assign slow_sel = {slow_b, slow_b, slow_a, slow_a};

  // Fast decay swaps the bridge and slow decay shorts the coil on the low sides
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      high_next[i] = ~slow_sel[i] & (fast_sel[i] ^ pol[i]) & faultn & enable;
      low_next[i]  = slow_sel[i] | ~(fast_sel[i] ^ pol[i]) | ~enable;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      high_q <= '0;
      low_q  <= '1;
    end else begin
      high_q <= high_next ^ {4{invert_highside}};
      low_q  <= low_next ^ {4{invert_lowside}};
    end
  end

  assign phase_a1_h = high_q[0];
  assign phase_a2_h = high_q[1];
  assign phase_b1_h = high_q[2];
  assign phase_b2_h = high_q[3];
  assign phase_a1_l = low_q[0];
  assign phase_a2_l = low_q[1];
  assign phase_b1_l = low_q[2];
  assign phase_b2_l = low_q[3];

  // Fault latch set by an off time inside the minimum on time and held until reset
  always_ff @(posedge clk) begin
    if (!resetn) begin
      faultn <= 1'b1;
    end else if ((offtimer_start_a & min_on_busy_a) | (offtimer_start_b & min_on_busy_b)) begin
      faultn <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hw/microstepper_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "microstepper_macros.svh"

module microstepper_top (
  input  logic                        clk,
  input  logic                        resetn,
  input  logic                        step,
  input  logic                        dir,
  input  logic                        analog_cmp1,
  input  logic                        analog_cmp2,
  input  logic [`AXIL_ADDR_W-1:0]     awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [`AXIL_DATA_W-1:0]     wdata,
  input  logic [`AXIL_DATA_W/8-1:0]   wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output logic                        bvalid,
  output logic [1:0]                  bresp,
  input  logic                        bready,
  input  logic [`AXIL_ADDR_W-1:0]     araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic                        rvalid,
  output logic [`AXIL_DATA_W-1:0]     rdata,
  output logic [1:0]                  rresp,
  input  logic                        rready,
  output logic                        phase_a1_h,
  output logic                        phase_a2_h,
  output logic                        phase_b1_h,
  output logic                        phase_b2_h,
  output logic                        phase_a1_l,
  output logic                        phase_a2_l,
  output logic                        phase_b1_l,
  output logic                        phase_b2_l,
  output logic                        faultn,
  output microstepper_pkg::level_t    dac_a,
  output microstepper_pkg::level_t    dac_b
);

  import microstepper_pkg::*;

  logic       enable;
  logic       invert_highside;
  logic       invert_lowside;
  timer_t     off_time;
  timer_t     fastdecay_threshold;
  logic [7:0] blank_time;
  logic [7:0] min_on_time;
  phase_t     phase_a;
  phase_t     phase_b;
  logic       s1;
  logic       s2;
  logic       s3;
  logic       s4;
  logic       offtimer_start_a;
  logic       offtimer_start_b;
  timer_t     off_count_a;
  timer_t     off_count_b;
  logic       blank_busy_a;
  logic       blank_busy_b;
  logic       min_on_busy_a;
  logic       min_on_busy_b;

  axil_config_regs i_regs (
    .clk                 (clk),
    .resetn              (resetn),
    .awaddr              (awaddr),
    .awvalid             (awvalid),
    .awready             (awready),
    .wdata               (wdata),
    .wstrb               (wstrb),
    .wvalid              (wvalid),
    .wready              (wready),
    .bvalid              (bvalid),
    .bresp               (bresp),
    .bready              (bready),
    .araddr              (araddr),
    .arvalid             (arvalid),
    .arready             (arready),
    .rvalid              (rvalid),
    .rdata               (rdata),
    .rresp               (rresp),
    .rready              (rready),
    .phase_a             (phase_a),
    .phase_b             (phase_b),
    .faultn              (faultn),
    .enable              (enable),
    .invert_highside     (invert_highside),
    .invert_lowside      (invert_lowside),
    .off_time            (off_time),
    .fastdecay_threshold (fastdecay_threshold),
    .blank_time          (blank_time),
    .min_on_time         (min_on_time)
  );

  microstep_sequencer i_sequencer (
    .clk     (clk),
    .resetn  (resetn),
    .phase_a (phase_a),
    .phase_b (phase_b),
    .s1      (s1),
    .s2      (s2),
    .s3      (s3),
    .s4      (s4),
    .dac_a   (dac_a),
    .dac_b   (dac_b)
  );

  coil_timer i_timer_a (
    .clk         (clk),
    .resetn      (resetn),
    .start       (offtimer_start_a),
    .off_time    (off_time),
    .blank_time  (blank_time),
    .min_on_time (min_on_time),
    .off_count   (off_count_a),
    .blank_busy  (blank_busy_a),
    .min_on_busy (min_on_busy_a)
  );

  coil_timer i_timer_b (
    .clk         (clk),
    .resetn      (resetn),
    .start       (offtimer_start_b),
    .off_time    (off_time),
    .blank_time  (blank_time),
    .min_on_time (min_on_time),
    .off_count   (off_count_b),
    .blank_busy  (blank_busy_b),
    .min_on_busy (min_on_busy_b)
  );

  microstepper_control i_control (
    .clk                 (clk),
    .resetn              (resetn),
    .step                (step),
    .dir                 (dir),
    .analog_cmp1         (analog_cmp1),
    .analog_cmp2         (analog_cmp2),
    .enable              (enable),
    .invert_highside     (invert_highside),
    .invert_lowside      (invert_lowside),
    .fastdecay_threshold (fastdecay_threshold),
    .s1                  (s1),
    .s2                  (s2),
    .s3                  (s3),
    .s4                  (s4),
    .off_count_a         (off_count_a),
    .off_count_b         (off_count_b),
    .blank_busy_a        (blank_busy_a),
    .blank_busy_b        (blank_busy_b),
    .min_on_busy_a       (min_on_busy_a),
    .min_on_busy_b       (min_on_busy_b),
    .phase_a             (phase_a),
    .phase_b             (phase_b),
    .offtimer_start_a    (offtimer_start_a),
    .offtimer_start_b    (offtimer_start_b),
    .faultn              (faultn),
    .phase_a1_h          (phase_a1_h),
    .phase_a2_h          (phase_a2_h),
    .phase_b1_h          (phase_b1_h),
    .phase_b2_h          (phase_b2_h),
    .phase_a1_l          (phase_a1_l),
    .phase_a2_l          (phase_a2_l),
    .phase_b1_l          (phase_b1_l),
    .phase_b2_l          (phase_b2_l)
  );

endmodule

`default_nettype wire

/* test/tb_microstepper.sv */
`timescale 1ns/1ps
`default_nettype none

`include "microstepper_macros.svh"

module tb_microstepper;

  import microstepper_pkg::*;

  localparam int HALF = `MS_CYCLE / 2;
  localparam int QUARTER = `MS_CYCLE / 4;
  localparam int HANDSHAKE_LIMIT = 20;
  localparam int MODE_DRIVE = 0;
  localparam int MODE_FAST = 1;
  localparam int MODE_SLOW = 2;
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic clk = 1'b0;
  logic resetn;
  logic step;
  logic dir;
  logic analog_cmp1;
  logic analog_cmp2;
  logic [`AXIL_ADDR_W-1:0] awaddr;
  logic awvalid;
  logic awready;
  logic [`AXIL_DATA_W-1:0] wdata;
  logic [`AXIL_DATA_W/8-1:0] wstrb;
  logic wvalid;
  logic wready;
  logic bvalid;
  logic [1:0] bresp;
  logic bready;
  logic [`AXIL_ADDR_W-1:0] araddr;
  logic arvalid;
  logic arready;
  logic rvalid;
  logic [`AXIL_DATA_W-1:0] rdata;
  logic [1:0] rresp;
  logic rready;
  logic phase_a1_h;
  logic phase_a2_h;
  logic phase_b1_h;
  logic phase_b2_h;
  logic phase_a1_l;
  logic phase_a2_l;
  logic phase_b1_l;
  logic phase_b2_l;
  logic faultn;
  level_t dac_a;
  level_t dac_b;

  // Model state of the driver
  phase_t model_pa;
  phase_t model_pb;
  logic model_en;
  logic model_fn;
  logic model_inv_h;
  logic model_inv_l;
  int errors = 0;
  int timeouts = 0;

  microstepper_top i_microstepper_top (
    .clk(clk), .resetn(resetn), .step(step), .dir(dir),
    .analog_cmp1(analog_cmp1), .analog_cmp2(analog_cmp2),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bvalid(bvalid), .bresp(bresp), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
    .phase_a1_h(phase_a1_h), .phase_a2_h(phase_a2_h),
    .phase_b1_h(phase_b1_h), .phase_b2_h(phase_b2_h),
    .phase_a1_l(phase_a1_l), .phase_a2_l(phase_a2_l),
    .phase_b1_l(phase_b1_l), .phase_b2_l(phase_b2_l),
    .faultn(faultn), .dac_a(dac_a), .dac_b(dac_b)
  );

  always #5 clk = ~clk;

  function automatic phase_t stepped_phase(input phase_t p, input logic up);
    int n;
    n = up ? int'(p) + 1 : int'(p) + `MS_CYCLE - 1;
    return phase_t'(n % `MS_CYCLE);
  endfunction

  // Triangle that rises by 5 per count over a quarter cycle and then falls back
  function automatic level_t expected_level(input phase_t p);
    int m;
    m = int'(p) % HALF;
    if (m < QUARTER) begin
      return level_t'(5 * m);
    end
    return level_t'(5 * (HALF - 1 - m));
  endfunction

  // Bit order {b2_h, b1_h, a2_h, a1_h, b2_l, b1_l, a2_l, a1_l}
  function automatic logic [7:0] expected_bridges(input phase_t pa, input phase_t pb,
                                                  input int mode_a, input int mode_b,
                                                  input logic en, input logic fn,
                                                  input logic inv_h, input logic inv_l);
    logic [3:0] pol;
    logic [3:0] hi;
    logic [3:0] lo;
    logic eff;
    int mode;
    pol = {int'(pb) >= HALF, int'(pb) < HALF, int'(pa) >= HALF, int'(pa) < HALF};
    for (int i = 0; i < 4; i++) begin
      mode = (i < 2) ? mode_a : mode_b;
      eff = (mode == MODE_FAST) ? ~pol[i] : pol[i];
      hi[i] = (mode != MODE_SLOW) && eff && fn && en;
      lo[i] = (mode == MODE_SLOW) || !eff || !en;
    end
    return {hi ^ {4{inv_h}}, lo ^ {4{inv_l}}};
  endfunction

  task automatic check_phase(input string what, input phase_t got, input phase_t exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_level(input string what, input level_t got, input level_t exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_bridges(input string what, input logic [7:0] got,
                               input logic [7:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s bridges are %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s reads %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input string what, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s response %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic apply_reset();
    resetn = 1'b0;
    idle(8);
    resetn = 1'b1;
    model_pa = '0;
    model_pb = phase_t'(`MS_B_OFFSET);
    model_en = 1'b0;
    model_fn = 1'b1;
    model_inv_h = 1'b0;
    model_inv_l = 1'b0;
    idle(4);
  endtask

  task automatic axil_write(input reg_addr_t addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
    int n;
    awaddr = addr;
    wdata = data;
    wstrb = strb;
    awvalid = 1'b1;
    wvalid = 1'b1;
    bready = 1'b1;
    n = 0;
    while (!(awready && wready) && n < HANDSHAKE_LIMIT) begin
      next_cycle();
      n++;
    end
    if (!(awready && wready)) begin
      timeouts++;
      $display("Timeout at %0t: the DUT never accepted the write address and data", $time);
    end
    next_cycle();
    awvalid = 1'b0;
    wvalid = 1'b0;
    n = 0;
    while (!bvalid && n < HANDSHAKE_LIMIT) begin
      next_cycle();
      n++;
    end
    if (!bvalid) begin
      timeouts++;
      $display("Timeout at %0t: the DUT gave no write response", $time);
    end
    resp = bresp;
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic axil_read(input reg_addr_t addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    araddr = addr;
    arvalid = 1'b1;
    rready = 1'b1;
    n = 0;
    while (!arready && n < HANDSHAKE_LIMIT) begin
      next_cycle();
      n++;
    end
    if (!arready) begin
      timeouts++;
      $display("Timeout at %0t: the DUT never accepted the read address", $time);
    end
    next_cycle();
    arvalid = 1'b0;
    n = 0;
    while (!rvalid && n < HANDSHAKE_LIMIT) begin
      next_cycle();
      n++;
    end
    if (!rvalid) begin
      timeouts++;
      $display("Timeout at %0t: the DUT gave no read data", $time);
    end
    data = rdata;
    resp = rresp;
    next_cycle();
    rready = 1'b0;
  endtask

  task automatic write_reg(input reg_addr_t addr, input logic [31:0] data);
    logic [1:0] resp;
    axil_write(addr, data, 4'hF, resp);
    check_resp("register write", resp, RESP_OKAY);
  endtask

  task automatic read_expect(input string what, input reg_addr_t addr, input logic [31:0] exp);
    logic [31:0] data;
    logic [1:0] resp;
    axil_read(addr, data, resp);
    check_resp(what, resp, RESP_OKAY);
    check_word(what, data, exp);
  endtask

  task automatic set_ctrl(input logic en, input logic inv_h, input logic inv_l);
    write_reg(ADDR_CTRL, {29'd0, inv_l, inv_h, en});
    model_en = en;
    model_inv_h = inv_h;
    model_inv_l = inv_l;
    idle(3);
  endtask

  task automatic check_outputs(input string what, input int mode_a, input int mode_b);
    check_level({what, " dac_a"}, dac_a, expected_level(model_pa));
    check_level({what, " dac_b"}, dac_b, expected_level(model_pb));
    check_flag({what, " faultn"}, faultn, model_fn);
    check_bridges(what,
                  {phase_b2_h, phase_b1_h, phase_a2_h, phase_a1_h,
                   phase_b2_l, phase_b1_l, phase_a2_l, phase_a1_l},
                  expected_bridges(model_pa, model_pb, mode_a, mode_b, model_en,
                                   model_fn, model_inv_h, model_inv_l));
  endtask

  task automatic check_status(input string what);
    read_expect(what, ADDR_STATUS, {15'd0, model_fn, model_pb, model_pa});
  endtask

  task automatic do_steps(input logic up, input int count);
    logic [31:0] data;
    logic [1:0] resp;
    for (int i = 0; i < count; i++) begin
      dir = up;
      idle(3);
      step = 1'b1;
      idle(4);
      step = 1'b0;
      idle(4);
      model_pa = stepped_phase(model_pa, up);
      model_pb = stepped_phase(model_pb, up);
      idle(6);
      axil_read(ADDR_STATUS, data, resp);
      check_resp("status", resp, RESP_OKAY);
      check_phase("phase_a", phase_t'(data[7:0]), model_pa);
      check_phase("phase_b", phase_t'(data[15:8]), model_pb);
      check_outputs("step", MODE_DRIVE, MODE_DRIVE);
    end
  endtask

  // Off time 40 and threshold 30 give 11 fast cycles and 29 slow ones
  task automatic decay_sequence(input string what);
    idle(30);
    analog_cmp1 = 1'b1;
    next_cycle();
    analog_cmp1 = 1'b0;
    idle(6);
    check_outputs({what, " fast"}, MODE_FAST, MODE_DRIVE);
    idle(20);
    check_outputs({what, " slow"}, MODE_SLOW, MODE_DRIVE);
    idle(33);
    check_outputs({what, " drive"}, MODE_DRIVE, MODE_DRIVE);
  endtask

  initial begin
    logic [31:0] data;
    logic [1:0] resp;
    int remaining;
    int run;
    logic up;
    void'($urandom(32'h20bb230d));
    resetn = 1'b0;
    step = 1'b0;
    dir = 1'b0;
    analog_cmp1 = 1'b0;
    analog_cmp2 = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    next_cycle();
    apply_reset();

    // Reset values and register access
    check_status("status after reset");
    read_expect("ctrl reset", ADDR_CTRL, 32'd0);
    read_expect("off reset", ADDR_OFF,
                {6'd0, 10'(`MS_FASTDECAY_DEFAULT), 6'd0, 10'(`MS_OFF_TIME_DEFAULT)});
    read_expect("times reset", ADDR_TIMES,
                {16'd0, 8'(`MS_MIN_ON_DEFAULT), 8'(`MS_BLANK_TIME_DEFAULT)});
    check_outputs("disabled", MODE_DRIVE, MODE_DRIVE);
    write_reg(ADDR_OFF, 32'h022B_0141);
    read_expect("off", ADDR_OFF, 32'h022B_0141);
    axil_write(ADDR_OFF, 32'hFFFF_0155, 4'b0011, resp);
    check_resp("off low bytes", resp, RESP_OKAY);
    read_expect("off low bytes", ADDR_OFF, 32'h022B_0155);
    write_reg(ADDR_TIMES, 32'h0000_3C1E);
    read_expect("times", ADDR_TIMES, 32'h0000_3C1E);
    write_reg(ADDR_CTRL, 32'h0000_0006);
    read_expect("ctrl", ADDR_CTRL, 32'h0000_0006);
    axil_write(reg_addr_t'(4'h2), 32'h1234_5678, 4'hF, resp);
    check_resp("unmapped write", resp, RESP_SLVERR);
    axil_read(reg_addr_t'(4'h2), data, resp);
    check_resp("unmapped read", resp, RESP_SLVERR);

    // Stepping starts with a walk across both ends of the cycle
    write_reg(ADDR_OFF, {6'd0, 10'd30, 6'd0, 10'd40});
    write_reg(ADDR_TIMES, {16'd0, 8'd0, 8'd20});
    set_ctrl(1'b1, 1'b0, 1'b0);
    check_outputs("enabled", MODE_DRIVE, MODE_DRIVE);
    do_steps(1'b0, 3);
    do_steps(1'b1, 5);
    remaining = 292;
    while (remaining > 0) begin
      run = int'($urandom_range(40, 1));
      if (run > remaining) begin
        run = remaining;
      end
      up = 1'($urandom_range(1, 0));
      do_steps(up, run);
      remaining = remaining - run;
    end

    // Decay and then the same with both output polarities inverted
    decay_sequence("decay");
    set_ctrl(1'b1, 1'b1, 1'b1);
    check_outputs("inverted", MODE_DRIVE, MODE_DRIVE);
    decay_sequence("inverted decay");
    set_ctrl(1'b0, 1'b1, 1'b1);
    check_outputs("inverted disabled", MODE_DRIVE, MODE_DRIVE);
    set_ctrl(1'b1, 1'b1, 1'b0);
    check_outputs("high side inverted", MODE_DRIVE, MODE_DRIVE);
    set_ctrl(1'b1, 1'b0, 1'b0);

    // Second off time on coil B lands inside its minimum on time
    write_reg(ADDR_TIMES, {16'd0, 8'd50, 8'd20});
    idle(30);
    analog_cmp2 = 1'b1;
    next_cycle();
    analog_cmp2 = 1'b0;
    idle(64);
    check_flag("faultn before second off time", faultn, 1'b1);
    analog_cmp2 = 1'b1;
    next_cycle();
    analog_cmp2 = 1'b0;
    model_fn = 1'b0;
    idle(2);
    check_outputs("fault", MODE_DRIVE, MODE_FAST);
    idle(60);
    check_outputs("fault held", MODE_DRIVE, MODE_DRIVE);
    check_status("status in fault");
    apply_reset();
    check_status("status after second reset");
    check_outputs("after second reset", MODE_DRIVE, MODE_DRIVE);

    $display("Run complete: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+common
common/microstepper_pkg.sv
hw/microstep_sequencer.sv
hw/coil_timer.sv
hw/axil_config_regs.sv
hw/microstepper_control.sv
hw/microstepper_top.sv
test/tb_microstepper.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_microstepper
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf $(OBJ_DIR)
